/* logic/sample_pack_macros.svh */
`ifndef SAMPLE_PACK_MACROS_SVH
`define SAMPLE_PACK_MACROS_SVH

// bits in one sample unit
`define SP_UNIT_W 8

// units carried by one channel input word
`define SP_IN_UNITS 4

// units in one packed channel word, never below SP_IN_UNITS
`define SP_OUT_UNITS 6

`endif

/* logic/sample_pack_pkg.sv */
`include "sample_pack_macros.svh"

package sample_pack_pkg;

  // one byte-sized sample unit
  typedef logic [`SP_UNIT_W-1:0] unit_t;

  // raw channel input word, unit 0 in the low bits
  typedef logic [`SP_IN_UNITS*`SP_UNIT_W-1:0] in_word_t;

  // packed channel word, lowest lanes filled first
  typedef logic [`SP_OUT_UNITS*`SP_UNIT_W-1:0] out_word_t;

  // channel 0 low half, channel 1 high half
  typedef logic [2*`SP_OUT_UNITS*`SP_UNIT_W-1:0] frame_t;

  // units held in a carry buffer, up to in + out - 1
  typedef logic [$clog2(`SP_IN_UNITS+`SP_OUT_UNITS)-1:0] fill_t;

endpackage

/* logic/unit_packer.sv */
`timescale 1ns/1ps

`include "sample_pack_macros.svh"

module unit_packer (
  input  logic                       clk,
  input  logic                       rst,
  input  sample_pack_pkg::in_word_t  in_data,
  input  logic                       in_valid,
  output sample_pack_pkg::out_word_t word,
  output logic                       word_valid
);

  localparam int UNIT_W    = `SP_UNIT_W;
  localparam int IN_UNITS  = `SP_IN_UNITS;
  localparam int OUT_UNITS = `SP_OUT_UNITS;
  localparam int OUT_W     = OUT_UNITS * UNIT_W;

  // out - 1 leftover units plus one fresh input word at most
  localparam int BUF_UNITS = IN_UNITS + OUT_UNITS - 1;
  localparam int BUF_W     = BUF_UNITS * UNIT_W;

  // held units with the oldest byte in lane 0
  logic [BUF_W-1:0]       carry_q;
  sample_pack_pkg::fill_t fill_q;

  // buffer contents once the current input is appended
  logic [BUF_W-1:0]       merged;

  // what stays behind after a word is taken out
  logic [BUF_W-1:0]       remain;

  sample_pack_pkg::fill_t fill_sum;
  sample_pack_pkg::fill_t fill_left;
  logic                   word_done;

  // input unit 0 goes to the first free lane and the rest follow upward
  always_comb begin
    int                     lane;
    sample_pack_pkg::unit_t in_unit;

    in_unit = '0;
    merged  = carry_q;
    for (int i = 0; i < BUF_UNITS; i++) begin
      lane = i - int'(fill_q);
      if (lane >= 0 && lane < IN_UNITS) begin
        in_unit = in_data[lane*UNIT_W +: UNIT_W];
        merged[i*UNIT_W +: UNIT_W] = in_unit;
      end
    end
  end

  assign fill_sum  = fill_q + sample_pack_pkg::fill_t'(IN_UNITS);
  assign fill_left = fill_sum - sample_pack_pkg::fill_t'(OUT_UNITS);

  // one input word can complete at most one output word
  assign word_done = in_valid && (fill_sum >= sample_pack_pkg::fill_t'(OUT_UNITS));

  // leftover lanes slide down in order
  assign remain = merged >> OUT_W;

  always_ff @(posedge clk) begin
    if (rst) begin
      fill_q     <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= word_done;
      if (word_done) begin
        fill_q <= fill_left;
      end else if (in_valid) begin
        fill_q <= fill_sum;
      end
    end
  end

  // live units sit below fill_q
  always_ff @(posedge clk) begin
    if (in_valid) begin
      if (word_done) begin
        carry_q <= remain;
      end else begin
        carry_q <= merged;
      end
    end
  end

  // lowest out units leave as one word
  always_ff @(posedge clk) begin
    if (word_done) begin
      word <= merged[OUT_W-1:0];
    end
  end

endmodule

/* logic/lane_merger.sv */
`timescale 1ns/1ps

module lane_merger (
  input  logic                       clk,
  input  logic                       rst,
  input  sample_pack_pkg::out_word_t word0,
  input  sample_pack_pkg::out_word_t word1,
  input  logic                       word0_valid,
  input  logic                       word1_valid,
  output sample_pack_pkg::frame_t    frame_data,
  output logic                       frame_valid,
  output logic                       overflow
);

  localparam int CHANNELS = 2;

  // per channel view of the inputs
  sample_pack_pkg::out_word_t word_in [CHANNELS];
  logic [CHANNELS-1:0]        strobe;

  // one pending word per channel
  sample_pack_pkg::out_word_t slot_q [CHANNELS];
  logic [CHANNELS-1:0]        full_q;

  logic                       emit;
  logic [CHANNELS-1:0]        take;
  logic [CHANNELS-1:0]        drop;

  assign word_in[0] = word0;
  assign word_in[1] = word1;
  assign strobe     = {word1_valid, word0_valid};

  // both halves present
  assign emit = &full_q;

  // a slot accepts when empty or when it empties on this edge
  assign take = strobe & (~full_q | {CHANNELS{emit}});

  // word for a channel already a full word ahead
  assign drop = strobe & ~take;

  always_ff @(posedge clk) begin
    if (rst) begin
      full_q      <= '0;
      frame_valid <= 1'b0;
      overflow    <= 1'b0;
    end else begin
      frame_valid <= emit;
      for (int c = 0; c < CHANNELS; c++) begin
        if (take[c]) begin
          full_q[c] <= 1'b1;
        end else if (emit) begin
          full_q[c] <= 1'b0;
        end
      end
      // sticky until reset
      if (|drop) begin
        overflow <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int c = 0; c < CHANNELS; c++) begin
      if (take[c]) begin
        slot_q[c] <= word_in[c];
      end
    end
    if (emit) begin
      frame_data <= {slot_q[1], slot_q[0]};
    end
  end

endmodule

/* logic/dual_sample_pack.sv */
`timescale 1ns/1ps

module dual_sample_pack (
  input  logic                      clk,
  input  logic                      rst,
  input  sample_pack_pkg::in_word_t ch0_data,
  input  sample_pack_pkg::in_word_t ch1_data,
  input  logic                      ch0_valid,
  input  logic                      ch1_valid,
  output sample_pack_pkg::frame_t   frame_data,
  output logic                      frame_valid,
  output logic                      overflow
);

  // packed words on their way to the merger
  sample_pack_pkg::out_word_t word0;
  sample_pack_pkg::out_word_t word1;
  logic                       word0_valid;
  logic                       word1_valid;

  // channel 0, low half of the frame
  unit_packer pack0 (
    .clk        (clk),
    .rst        (rst),
    .in_data    (ch0_data),
    .in_valid   (ch0_valid),
    .word       (word0),
    .word_valid (word0_valid)
  );

  // channel 1, high half
  unit_packer pack1 (
    .clk        (clk),
    .rst        (rst),
    .in_data    (ch1_data),
    .in_valid   (ch1_valid),
    .word       (word1),
    .word_valid (word1_valid)
  );

  lane_merger merge (
    .clk         (clk),
    .rst         (rst),
    .word0       (word0),
    .word1       (word1),
    .word0_valid (word0_valid),
    .word1_valid (word1_valid),
    .frame_data  (frame_data),
    .frame_valid (frame_valid),
    .overflow    (overflow)
  );

endmodule

/* bench/pack_ref.svh */
`ifndef PACK_REF_SVH
`define PACK_REF_SVH

// fibonacci lfsr, taps at bits 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one step per bit taken, newest bit lowest
function automatic logic [31:0] take_bits(input int n);
  logic [31:0] bits;
  bits = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_q = lfsr_next(lfsr_q);
    bits = {bits[30:0], lfsr_q[0]};
  end
  return bits;
endfunction

// counting bytes, separate start per channel
function automatic void add_counting(input int words, input int base0, input int base1);
  for (int i = 0; i < words * `SP_IN_UNITS; i++) begin
    stream0.push_back(sample_pack_pkg::unit_t'(base0 + i));
    stream1.push_back(sample_pack_pkg::unit_t'(base1 + i));
  end
endfunction

function automatic void add_random(input int words);
  for (int i = 0; i < words * `SP_IN_UNITS; i++) begin
    stream0.push_back(sample_pack_pkg::unit_t'(take_bits(`SP_UNIT_W)));
    stream1.push_back(sample_pack_pkg::unit_t'(take_bits(`SP_UNIT_W)));
  end
endfunction

// frame k is word k of each stream, lowest byte first, channel 1 on top
function automatic sample_pack_pkg::frame_t ref_frame(input int k);
  sample_pack_pkg::frame_t f;
  int                      base;
  f    = '0;
  base = k * `SP_OUT_UNITS;
  for (int b = 0; b < `SP_OUT_UNITS; b++) begin
    f[b*`SP_UNIT_W +: `SP_UNIT_W]                   = stream0[base+b];
    f[(b+`SP_OUT_UNITS)*`SP_UNIT_W +: `SP_UNIT_W]   = stream1[base+b];
  end
  return f;
endfunction

`endif

/* bench/dual_sample_pack_tb.sv */
`timescale 1ns/1ps

`include "sample_pack_macros.svh"

module dual_sample_pack_tb;

  // input words over all five tests, both channels
  localparam int TOTAL_WORDS = 131;
  localparam int CYCLE_LIMIT = 3 * TOTAL_WORDS + 200;

  logic                      clk = 1'b0;
  logic                      rst;
  sample_pack_pkg::in_word_t ch0_data;
  sample_pack_pkg::in_word_t ch1_data;
  logic                      ch0_valid;
  logic                      ch1_valid;
  sample_pack_pkg::frame_t   frame_data;
  logic                      frame_valid;
  logic                      overflow;

  logic [31:0]             lfsr_q = 32'hd969_e257;
  sample_pack_pkg::unit_t  stream0 [$];
  sample_pack_pkg::unit_t  stream1 [$];
  sample_pack_pkg::frame_t exp_q [$];
  int sent0 = 0;
  int sent1 = 0;
  int frames_seen = 0;
  int main_errors = 0;
  int checker_errors = 0;
  int errors_at_start = 0;
  int test_count = 0;
  int tests_failed = 0;
  int cycles = 0;

  `include "pack_ref.svh"

  dual_sample_pack UUT (
    .clk         (clk),
    .rst         (rst),
    .ch0_data    (ch0_data),
    .ch1_data    (ch1_data),
    .ch0_valid   (ch0_valid),
    .ch1_valid   (ch1_valid),
    .frame_data  (frame_data),
    .frame_valid (frame_valid),
    .overflow    (overflow)
  );

  always #10 clk = ~clk;

  function automatic int words_out(input int words_in);
    return words_in * `SP_IN_UNITS / `SP_OUT_UNITS;
  endfunction

  // hold back an input that would put this channel two words ahead
  function automatic logic may_send(input int mine, input int other);
    logic completes;
    completes = words_out(mine + 1) > words_out(mine);
    return !completes || words_out(mine) <= words_out(other);
  endfunction

  function automatic sample_pack_pkg::in_word_t stream_word(input int ch, input int idx);
    sample_pack_pkg::in_word_t w;
    int                        pos;
    w = '0;
    for (int u = 0; u < `SP_IN_UNITS; u++) begin
      pos = idx * `SP_IN_UNITS + u;
      if (ch == 0) begin
        w[u*`SP_UNIT_W +: `SP_UNIT_W] = stream0[pos];
      end else begin
        w[u*`SP_UNIT_W +: `SP_UNIT_W] = stream1[pos];
      end
    end
    return w;
  endfunction

  function automatic void queue_expected(input int first, input int count);
    for (int k = first; k < first + count; k++) begin
      exp_q.push_back(ref_frame(k));
    end
  endfunction

  task automatic check_frame(input string name, input sample_pack_pkg::frame_t expected,
                             input sample_pack_pkg::frame_t found);
    if (found !== expected) begin
      $display("Fail at %0t: %s expected %h found %h", $time, name, expected, found);
      checker_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic found);
    if (found !== expected) begin
      $display("Fail at %0t: %s expected %b found %b", $time, name, expected, found);
      main_errors++;
    end
  endtask

  task automatic drive_cycle(input logic v0, input logic v1);
    @(posedge clk);
    #1;
    ch0_valid = v0;
    ch1_valid = v1;
    if (v0) begin
      ch0_data = stream_word(0, sent0);
      sent0++;
    end
    if (v1) begin
      ch1_data = stream_word(1, sent1);
      sent1++;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) drive_cycle(1'b0, 1'b0);
  endtask

  // streams restart from their first byte after reset
  task automatic apply_reset();
    @(posedge clk);
    #1;
    rst       = 1'b1;
    ch0_valid = 1'b0;
    ch1_valid = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    stream0.delete();
    stream1.delete();
    sent0 = 0;
    sent1 = 0;
  endtask

  task automatic wait_frames();
    int waited;
    waited = 0;
    while (frames_seen < exp_q.size() && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (frames_seen < exp_q.size()) begin
      $display("Error at %0t: %0d expected frames never arrived", $time,
               exp_q.size() - frames_seen);
      main_errors++;
    end
    // room for a stray frame to show up
    repeat (6) @(posedge clk);
  endtask

  task automatic end_test(input string name);
    int    errs;
    string verdict;
    errs = main_errors + checker_errors - errors_at_start;
    test_count++;
    if (errs == 0) begin
      verdict = "passed";
    end else begin
      verdict = "failed";
      tests_failed++;
    end
    $display("Test %0d %s: %s, %0d errors", test_count, name, verdict, errs);
    errors_at_start = main_errors + checker_errors;
  endtask

  // frames checked in arrival order
  always @(negedge clk) begin
    if (!rst && frame_valid) begin
      if (frames_seen < exp_q.size()) begin
        check_frame("frame_data", exp_q[frames_seen], frame_data);
        frames_seen++;
      end else begin
        $display("Error at %0t: frame arrived with no frame expected", $time);
        checker_errors++;
      end
    end
  end

  initial begin
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: run stopped after %0d cycles", cycles);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    logic [31:0] coin;
    logic        v0;
    logic        v1;
    rst       = 1'b1;
    ch0_data  = '0;
    ch1_data  = '0;
    ch0_valid = 1'b0;
    ch1_valid = 1'b0;

    apply_reset();
    add_counting(24, 0, 128);
    queue_expected(0, 16);
    repeat (24) drive_cycle(1'b1, 1'b1);
    idle(1);
    wait_frames();
    check_flag("overflow", 1'b0, overflow);
    end_test("counting lockstep");

    apply_reset();
    add_random(24);
    queue_expected(0, 16);
    while (sent0 < 24 || sent1 < 24) begin
      coin = take_bits(2);
      v0 = coin[0] && (sent0 < 24) && may_send(sent0, sent1);
      v1 = coin[1] && (sent1 < 24) && may_send(sent1, sent0);
      drive_cycle(v0, v1);
    end
    idle(1);
    wait_frames();
    check_flag("overflow", 1'b0, overflow);
    end_test("random gaps");

    apply_reset();
    add_counting(3, 16, 160);
    queue_expected(0, 2);
    repeat (3) drive_cycle(1'b1, 1'b1);
    idle(1);
    wait_frames();
    add_counting(3, 28, 172);
    queue_expected(2, 2);
    repeat (3) drive_cycle(1'b1, 1'b1);
    idle(1);
    wait_frames();
    check_flag("overflow", 1'b0, overflow);
    end_test("leftover carry");

    // second channel 0 word finds its slot still full
    apply_reset();
    add_counting(3, 64, 200);
    queue_expected(0, 1);
    repeat (3) drive_cycle(1'b1, 1'b0);
    idle(3);
    check_flag("overflow", 1'b1, overflow);
    repeat (3) drive_cycle(1'b0, 1'b1);
    idle(1);
    wait_frames();
    check_flag("overflow", 1'b1, overflow);
    end_test("channel skew");

    apply_reset();
    add_counting(4, 90, 230);
    drive_cycle(1'b1, 1'b1);
    repeat (3) drive_cycle(1'b1, 1'b0);
    idle(3);
    check_flag("overflow", 1'b1, overflow);
    apply_reset();
    check_flag("overflow", 1'b0, overflow);
    add_counting(6, 1, 101);
    queue_expected(0, 4);
    repeat (6) drive_cycle(1'b1, 1'b1);
    idle(1);
    wait_frames();
    check_flag("overflow", 1'b0, overflow);
    end_test("reset mid-stream");

    $display("Tests: %0d run, %0d passed, %0d failed", test_count,
             test_count - tests_failed, tests_failed);
    if (main_errors + checker_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+logic
+incdir+bench
logic/sample_pack_pkg.sv
logic/unit_packer.sv
logic/lane_merger.sv
logic/dual_sample_pack.sv
bench/dual_sample_pack_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with verilator

cd "$(dirname "$0")" || exit 1

TOP=dual_sample_pack_tb
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f build.f --top-module "$TOP" --Mdir "$BUILD_DIR" -o sim_bin
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/sim_bin" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# the log decides pass or fail
if grep -q "Finished with errors" "$LOG"; then
  echo "Simulation reported failures"
  exit 1
fi

if ! grep -q "Finished with no errors" "$LOG"; then
  echo "Simulation ended without a final result"
  exit 1
fi

echo "Simulation passed"
exit 0
